// ==== flist.f ====
+incdir+src
src/cpuPkg.sv
src/ctrlIf.sv
src/byteMemory.sv
src/registerFile.sv
src/alu.sv
src/dataPath.sv
src/controlUnit.sv
src/cpuTop.sv
test/tbClock.sv
test/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exits nonzero on any failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "NO ERRORS" sim.log; then
	exit 0
else
	echo "Pass message not found in sim.log"
	exit 1
fi

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
	localparam int TotalInstr = 100;	// loaded words plus retired instructions, rounded up.
	localparam int ClockNs = 4;

	logic clk, reset, hold, progWe, retire;
	cpuPkg::wordT progAddr, progData, dbgData, pc;
	cpuPkg::regIdxT dbgReg;

	cpuPkg::wordT prog[$];
	cpuPkg::wordT expPc[$];
	cpuPkg::wordT modelRegs [8];
	logic [7:0] modelMem [1024];
	cpuPkg::wordT modelPc;
	logic modelZ;
	logic [31:0] rngState;

	tbClock #(.Period(4.0), .ResetCycles(3)) clockGen (.hold(hold), .clk(clk), .reset(reset));

	cpuTop DUT (
		.clk(clk),
		.reset(reset),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.dbgReg(dbgReg),
		.dbgData(dbgData),
		.pc(pc),
		.retire(retire)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic cpuPkg::wordT encR(input logic [1:0] cond, input cpuPkg::opcodeT op,
		input logic s, input cpuPkg::regIdxT rd, input cpuPkg::regIdxT rs1,
		input cpuPkg::regIdxT rs2);
		return {cond, op, s, rd, rs1, rs2, 7'd0};
	endfunction

	function automatic cpuPkg::wordT encI(input logic [1:0] cond, input cpuPkg::opcodeT op,
		input logic s, input cpuPkg::regIdxT rd, input cpuPkg::regIdxT rs1, input logic [9:0] imm);
		return {cond, op, s, rd, rs1, imm};
	endfunction

	function automatic cpuPkg::wordT encJ(input cpuPkg::opcodeT op, input logic [16:0] imm);
		return {2'b00, op, imm};
	endfunction

	function automatic logic [9:0] randImm();
		rngState = xorshift(rngState);
		return rngState[9:0];
	endfunction

	task automatic compareWord(input string name, input cpuPkg::wordT exp, input cpuPkg::wordT act);
		if (act !== exp)
		begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic compareBit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// reference model of one instruction, written from the ISA rules.
	task automatic modelStep();
		cpuPkg::wordT ir, a, b, d, imm, res, addr, next;
		logic [18:0] jmp;
		logic run;
		ir = prog[modelPc / 3];
		a = modelRegs[ir[12:10]];
		b = modelRegs[ir[9:7]];
		d = modelRegs[ir[15:13]];
		imm = {{14{ir[9]}}, ir[9:0]};
		addr = a + imm;
		jmp = {2'b00, ir[16:0]} * 19'd3;
		next = modelPc + 24'd3;
		case (ir[23:22])
			2'b00: run = 1'b1;
			2'b01: run = modelZ;
			2'b10: run = !modelZ;
			default: run = 1'b0;
		endcase
		if (run && ir[21:17] <= 5'd6)
		begin
			case (ir[21:17])
				5'd0: res = a & b;
				5'd1: res = a + b;
				5'd2: res = a - b;
				5'd3: res = a << b[4:0];
				5'd4: res = (a > b) ? a : b;
				5'd5: res = a & imm;
				default: res = a + imm;
			endcase
			if (ir[16])
				modelZ = (res == '0);
			modelRegs[ir[15:13]] = res;
		end
		else if (run)
		begin
			case (ir[21:17])
				5'd7: modelRegs[ir[15:13]] = {modelMem[(addr + 0) % 1024],
					modelMem[(addr + 1) % 1024], modelMem[(addr + 2) % 1024]};
				5'd8:
				begin
					modelMem[(addr + 0) % 1024] = d[23:16];
					modelMem[(addr + 1) % 1024] = d[15:8];
					modelMem[(addr + 2) % 1024] = d[7:0];
				end
				5'd9: if (d == a) next = modelPc + 24'd3 + imm * 24'd3;
				5'd10: next = {modelPc[23:19], jmp};
				5'd11: next = a;
				5'd12:
				begin
					modelRegs[7] = modelPc + 24'd3;
					next = {modelPc[23:19], jmp};
				end
				default: next = next;
			endcase
		end
		modelRegs[0] = '0;
		modelPc = next;
	endtask

	task automatic runProgram(input string name, input int count);
		modelPc = '0;
		modelZ = 1'b0;
		foreach (modelRegs[r])
			modelRegs[r] = '0;
		expPc.delete();
		repeat (count)
		begin
			modelStep();
			expPc.push_back(modelPc);
		end
		prog.push_back(encJ(cpuPkg::OP_J, 17'(prog.size())));	// parks the core in a loop.
		@(posedge clk);
		#1 hold = 1'b1;
		foreach (prog[i])
		begin
			progWe = 1'b1;
			progAddr = cpuPkg::wordT'(3 * i);
			progData = prog[i];
			@(posedge clk);
			#1;
		end
		progWe = 1'b0;
		hold = 1'b0;
		foreach (expPc[i])
		begin
			do @(negedge clk); while (retire !== 1'b1);
			@(posedge clk);
			#1 compareWord($sformatf("%s pc after retire %0d", name, i), expPc[i], pc);
		end
		for (int r = 0; r < 8; r++)
		begin
			dbgReg = cpuPkg::regIdxT'(r);
			#1 compareWord($sformatf("%s r%0d", name, r), modelRegs[r], dbgData);
			@(posedge clk);
			#1;
		end
		prog.delete();
	endtask

	task automatic resetCheck();
		@(posedge clk);
		#1 compareWord("reset pc", '0, pc);
		compareBit("reset retire", 1'b0, retire);
		for (int r = 0; r < 8; r++)
		begin
			dbgReg = cpuPkg::regIdxT'(r);
			#1 compareWord($sformatf("reset r%0d", r), '0, dbgData);
			@(posedge clk);
			#1;
		end
	endtask

	task automatic aluTest();
		for (int r = 1; r <= 3; r++)
			prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'(r), 3'd0, randImm()));
		prog.push_back(encR(2'b00, cpuPkg::OP_AND, 1'b0, 3'd4, 3'd1, 3'd2));
		prog.push_back(encR(2'b00, cpuPkg::OP_ADD, 1'b0, 3'd5, 3'd1, 3'd2));
		prog.push_back(encR(2'b00, cpuPkg::OP_SUB, 1'b0, 3'd6, 3'd1, 3'd2));
		prog.push_back(encR(2'b00, cpuPkg::OP_SLL, 1'b0, 3'd7, 3'd1, 3'd3));
		prog.push_back(encR(2'b00, cpuPkg::OP_MAX, 1'b0, 3'd1, 3'd2, 3'd5));
		prog.push_back(encI(2'b00, cpuPkg::OP_ANDI, 1'b0, 3'd2, 3'd4, randImm()));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd3, 3'd6, randImm()));
		prog.push_back(encR(2'b00, cpuPkg::OP_ADD, 1'b0, 3'd0, 3'd1, 3'd2));	// R0 stays zero.
		runProgram("alu", 11);
	endtask

	task automatic memoryTest();
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd1, 3'd0, randImm()));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd2, 3'd0, randImm()));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd3, 3'd0, 10'd30));
		prog.push_back(encI(2'b00, cpuPkg::OP_SW, 1'b0, 3'd1, 3'd3, 10'd0));
		prog.push_back(encI(2'b00, cpuPkg::OP_SW, 1'b0, 3'd2, 3'd3, 10'd3));
		prog.push_back(encI(2'b00, cpuPkg::OP_LW, 1'b0, 3'd4, 3'd3, 10'd0));
		prog.push_back(encI(2'b00, cpuPkg::OP_LW, 1'b0, 3'd5, 3'd3, 10'd3));
		prog.push_back(encI(2'b00, cpuPkg::OP_LW, 1'b0, 3'd6, 3'd3, 10'd1));
		prog.push_back(encI(2'b00, cpuPkg::OP_SW, 1'b0, 3'd2, 3'd0, 10'h3fe));	// wraps past 1023.
		prog.push_back(encI(2'b00, cpuPkg::OP_LW, 1'b0, 3'd7, 3'd0, 10'h3fe));
		runProgram("memory", 10);
	endtask

	task automatic conditionTest();
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd1, 3'd0, 10'd5));
		prog.push_back(encR(2'b00, cpuPkg::OP_SUB, 1'b1, 3'd2, 3'd1, 3'd1));
		prog.push_back(encI(2'b01, cpuPkg::OP_ADDI, 1'b0, 3'd3, 3'd0, 10'd7));
		prog.push_back(encI(2'b10, cpuPkg::OP_ADDI, 1'b0, 3'd4, 3'd0, 10'd9));
		prog.push_back(encR(2'b00, cpuPkg::OP_SUB, 1'b1, 3'd5, 3'd1, 3'd0));
		prog.push_back(encI(2'b01, cpuPkg::OP_ADDI, 1'b0, 3'd6, 3'd0, 10'd11));
		prog.push_back(encI(2'b10, cpuPkg::OP_ADDI, 1'b0, 3'd7, 3'd0, 10'd13));
		prog.push_back(encI(2'b11, cpuPkg::OP_ADDI, 1'b0, 3'd3, 3'd0, 10'd99));
		prog.push_back(encR(2'b00, cpuPkg::OP_SUB, 1'b1, 3'd2, 3'd1, 3'd1));
		prog.push_back(encR(2'b00, cpuPkg::OP_ADD, 1'b0, 3'd5, 3'd1, 3'd1));
		prog.push_back(encI(2'b01, cpuPkg::OP_ADDI, 1'b0, 3'd4, 3'd0, 10'd21));
		runProgram("condition", 11);
	endtask

	task automatic branchTest();
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd1, 3'd0, 10'd4));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd2, 3'd0, 10'd4));
		prog.push_back(encI(2'b00, cpuPkg::OP_BEQ, 1'b0, 3'd1, 3'd2, 10'd2));	// taken.
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd3, 3'd0, 10'd1));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd3, 3'd0, 10'd2));
		prog.push_back(encI(2'b00, cpuPkg::OP_BEQ, 1'b0, 3'd1, 3'd0, 10'd5));	// not taken.
		prog.push_back(encJ(cpuPkg::OP_CALL, 17'd10));
		prog.push_back(encJ(cpuPkg::OP_J, 17'd12));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd4, 3'd0, 10'd3));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd4, 3'd0, 10'd4));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd5, 3'd0, 10'd77));
		prog.push_back(encI(2'b00, cpuPkg::OP_JR, 1'b0, 3'd0, 3'd7, 10'd0));
		prog.push_back(encI(2'b00, cpuPkg::OP_ADDI, 1'b0, 3'd6, 3'd0, 10'd55));
		runProgram("branch", 9);
	endtask

	initial
	begin
		#(TotalInstr * 5 * 2 * ClockNs);
		$display("Timeout: the tests did not finish in the expected time.");
		$display("ERRORS FOUND");
		$fatal(1);
	end

	initial
	begin
		hold = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		dbgReg = '0;
		rngState = 32'h77a8f6ae;
		resetCheck();
		aluTest();
		memoryTest();
		conditionTest();
		branchTest();
		$display("NO ERRORS");
		$finish;
	end
endmodule

`default_nettype wire

// ==== test/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter real Period = 4.0,
	parameter int ResetCycles = 3
) (
	input wire logic hold,	// lets a test hold reset while it loads a program.
	output logic clk,
	output logic reset
);
	logic startDone;

	initial
	begin
		clk = 1'b0;
		startDone = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1 startDone = 1'b1;
	end

	always #(Period / 2.0) clk = ~clk;

	assign reset = startDone && !hold;	// active low.
endmodule

`default_nettype wire

// ==== src/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuDefines.svh"

module cpuTop (
	input wire logic clk,
	input wire logic reset,
	input wire logic progWe,
	input wire cpuPkg::wordT progAddr,
	input wire cpuPkg::wordT progData,
	input wire cpuPkg::regIdxT dbgReg,
	output cpuPkg::wordT dbgData,
	output cpuPkg::wordT pc,
	output logic retire
);
	cpuPkg::wordT imemAddr, imemData;
	cpuPkg::wordT dmemAddr, dmemWData, dmemRData;
	logic dmemWe;

	ctrlIf ctl ();

	controlUnit ctrlUnit (
		.clk(clk),
		.reset(reset),
		.ctl(ctl.ctrl),
		.retire(retire)
	);

	dataPath core (
		.clk(clk),
		.reset(reset),
		.ctl(ctl.dp),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.dmemAddr(dmemAddr),
		.dmemWData(dmemWData),
		.dmemRData(dmemRData),
		.dmemWe(dmemWe),
		.dbgReg(dbgReg),
		.dbgData(dbgData),
		.pc(pc)
	);

	// the program port is the only writer of the instruction memory.
	byteMemory #(.DEPTH(`MEM_DEPTH)) instrMem (
		.clk(clk),
		.we(progWe),
		.wAddr(progAddr),
		.wData(progData),
		.rAddr(imemAddr),
		.rData(imemData)
	);

	byteMemory #(.DEPTH(`MEM_DEPTH)) dataMem (
		.clk(clk),
		.we(dmemWe),
		.wAddr(dmemAddr),
		.wData(dmemWData),
		.rAddr(dmemAddr),
		.rData(dmemRData)
	);
endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input wire logic clk,
	input wire logic reset,
	ctrlIf.ctrl ctl,
	output logic retire
);
	cpuPkg::stateT state, nextState;
	logic zFlag;
	logic condPass;
	logic isAluType;

	function automatic cpuPkg::aluOpT aluOpFor(input cpuPkg::opcodeT opc);
		case (opc)
			cpuPkg::OP_AND, cpuPkg::OP_ANDI:
				return cpuPkg::ALU_AND;
			cpuPkg::OP_SUB, cpuPkg::OP_BEQ:
				return cpuPkg::ALU_SUB;
			cpuPkg::OP_SLL:
				return cpuPkg::ALU_SLL;
			cpuPkg::OP_MAX:
				return cpuPkg::ALU_MAX;
			default:
				return cpuPkg::ALU_ADD;	// also the address adder for LW and SW.
		endcase
	endfunction

	always_comb
	begin
		case (ctl.cond)
			2'b00: condPass = 1'b1;
			2'b01: condPass = zFlag;
			2'b10: condPass = !zFlag;
			default: condPass = 1'b0;
		endcase
	end

	assign isAluType = ctl.opcode inside {[cpuPkg::OP_AND:cpuPkg::OP_ADDI]};

	always_comb
	begin
		nextState = cpuPkg::FETCH;
		ctl.irLoad = 1'b0;
		ctl.pcLoad = 1'b0;
		ctl.pcSel = cpuPkg::PC_SEQ;
		ctl.aluOp = cpuPkg::ALU_ADD;
		ctl.aluSrcImm = 1'b0;
		ctl.opLoad = 1'b0;
		ctl.resultLoad = 1'b0;
		ctl.memWrite = 1'b0;
		ctl.mdrLoad = 1'b0;
		ctl.regWrite = 1'b0;
		ctl.wbSel = cpuPkg::WB_ALU;
		ctl.rdIsSource = 1'b0;
		retire = 1'b0;
		case (state)
			cpuPkg::FETCH:
			begin
				ctl.irLoad = 1'b1;
				nextState = cpuPkg::DECODE;
			end
			cpuPkg::DECODE:
			begin
				ctl.opLoad = 1'b1;
				ctl.rdIsSource = ctl.opcode inside {cpuPkg::OP_SW, cpuPkg::OP_BEQ};
				if (condPass)
					nextState = cpuPkg::EXECUTE;
				else
				begin
					// skipped by its condition so it retires here.
					ctl.pcLoad = 1'b1;
					retire = 1'b1;
				end
			end
			cpuPkg::EXECUTE:
			begin
				ctl.resultLoad = 1'b1;
				ctl.aluOp = aluOpFor(ctl.opcode);
				ctl.aluSrcImm = ctl.opcode inside {cpuPkg::OP_ANDI, cpuPkg::OP_ADDI,
					cpuPkg::OP_LW, cpuPkg::OP_SW};
				case (ctl.opcode)
					cpuPkg::OP_LW, cpuPkg::OP_SW:
						nextState = cpuPkg::MEMORY;
					cpuPkg::OP_BEQ:
					begin
						ctl.pcLoad = 1'b1;
						ctl.pcSel = ctl.aluZero ? cpuPkg::PC_BRANCH : cpuPkg::PC_SEQ;
						retire = 1'b1;
					end
					cpuPkg::OP_J:
					begin
						ctl.pcLoad = 1'b1;
						ctl.pcSel = cpuPkg::PC_JUMP;
						retire = 1'b1;
					end
					cpuPkg::OP_JR:
					begin
						ctl.pcLoad = 1'b1;
						ctl.pcSel = cpuPkg::PC_REG;
						retire = 1'b1;
					end
					cpuPkg::OP_CALL:
					begin
						ctl.pcLoad = 1'b1;
						ctl.pcSel = cpuPkg::PC_JUMP;
						ctl.regWrite = 1'b1;
						ctl.wbSel = cpuPkg::WB_LINK;
						retire = 1'b1;
					end
					default:
						nextState = cpuPkg::WRITEBACK;
				endcase
			end
			cpuPkg::MEMORY:
			begin
				if (ctl.opcode == cpuPkg::OP_LW)
				begin
					ctl.mdrLoad = 1'b1;
					nextState = cpuPkg::WRITEBACK;
				end
				else
				begin
					ctl.memWrite = 1'b1;
					ctl.pcLoad = 1'b1;
					retire = 1'b1;
				end
			end
			cpuPkg::WRITEBACK:
			begin
				ctl.pcLoad = 1'b1;
				ctl.regWrite = isAluType || (ctl.opcode == cpuPkg::OP_LW);	// no-ops write nothing.
				ctl.wbSel = (ctl.opcode == cpuPkg::OP_LW) ? cpuPkg::WB_MEM : cpuPkg::WB_ALU;
				retire = 1'b1;
			end
			default:
				nextState = cpuPkg::FETCH;
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= cpuPkg::FETCH;
			zFlag <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// only instructions that passed their condition reach EXECUTE.
			if (state == cpuPkg::EXECUTE && isAluType && ctl.sBit)
				zFlag <= ctl.aluZero;
		end
	end

	legalState: assert property (@(posedge clk) disable iff (!reset)
		state inside {cpuPkg::FETCH, cpuPkg::DECODE, cpuPkg::EXECUTE,
			cpuPkg::MEMORY, cpuPkg::WRITEBACK});
	noRetireInFetch: assert property (@(posedge clk) disable iff (!reset)
		state == cpuPkg::FETCH |-> !retire);
endmodule

`default_nettype wire

// ==== src/dataPath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuDefines.svh"

module dataPath (
	input wire logic clk,
	input wire logic reset,
	ctrlIf.dp ctl,
	output cpuPkg::wordT imemAddr,
	input wire cpuPkg::wordT imemData,
	output cpuPkg::wordT dmemAddr,
	output cpuPkg::wordT dmemWData,
	input wire cpuPkg::wordT dmemRData,
	output logic dmemWe,
	input wire cpuPkg::regIdxT dbgReg,
	output cpuPkg::wordT dbgData,
	output cpuPkg::wordT pc
);
	localparam int JumpW = `IMM17_W + 2;
	localparam cpuPkg::regIdxT LinkReg = cpuPkg::regIdxT'(7);

	cpuPkg::wordT irReg, pcReg, aReg, bReg, resultReg, mdrReg, linkReg;
	cpuPkg::wordT rDataA, rDataB, wbData, immExt, aluB, aluResult, nextPc;
	cpuPkg::regIdxT rd, rs1, rs2, rAddrB, wAddr;
	logic [JumpW-1:0] jumpOffset;
	logic aluZero;

	assign rd = irReg[`RD_HI -: `REG_ADDR_W];
	assign rs1 = irReg[`RS1_HI -: `REG_ADDR_W];
	assign rs2 = irReg[`RS2_HI -: `REG_ADDR_W];
	assign rAddrB = ctl.rdIsSource ? rd : rs2;
	assign wAddr = (ctl.wbSel == cpuPkg::WB_LINK) ? LinkReg : rd;	// CALL links into R7.

	assign immExt = {{(`WORD_W-`IMM10_W){irReg[`IMM10_W-1]}}, irReg[`IMM10_W-1:0]};
	assign aluB = ctl.aluSrcImm ? immExt : bReg;

	// three times imm17, kept to the low bits that replace the PC.
	assign jumpOffset = {2'b00, irReg[`IMM17_W-1:0]} + {1'b0, irReg[`IMM17_W-1:0], 1'b0};

	assign ctl.opcode = cpuPkg::opcodeT'(irReg[`OPC_HI:`OPC_LO]);
	assign ctl.cond = irReg[`COND_HI:`COND_LO];
	assign ctl.sBit = irReg[`S_BIT];
	assign ctl.aluZero = aluZero;

	always_comb
	begin
		case (ctl.pcSel)
			cpuPkg::PC_BRANCH:
				nextPc = linkReg + immExt + {immExt[`WORD_W-2:0], 1'b0};
			cpuPkg::PC_JUMP:
				nextPc = {pcReg[`WORD_W-1:JumpW], jumpOffset};
			cpuPkg::PC_REG:
				nextPc = aReg;
			default:
				nextPc = linkReg;	// linkReg already holds PC + 3.
		endcase
	end

	always_comb
	begin
		case (ctl.wbSel)
			cpuPkg::WB_MEM:
				wbData = mdrReg;
			cpuPkg::WB_LINK:
				wbData = linkReg;
			default:
				wbData = resultReg;
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			pcReg <= '0;
		else if (ctl.pcLoad)
			pcReg <= nextPc;
	end

	always_ff @(posedge clk)
	begin
		if (ctl.irLoad)
		begin
			irReg <= imemData;
			linkReg <= pcReg + cpuPkg::wordT'(`WORD_BYTES);
		end
		if (ctl.opLoad)
		begin
			aReg <= rDataA;
			bReg <= rDataB;
		end
		if (ctl.resultLoad)
			resultReg <= aluResult;
		if (ctl.mdrLoad)
			mdrReg <= dmemRData;
	end

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.rAddrA(rs1),
		.rAddrB(rAddrB),
		.rDataA(rDataA),
		.rDataB(rDataB),
		.we(ctl.regWrite),
		.wAddr(wAddr),
		.wData(wbData),
		.dbgAddr(dbgReg),
		.dbgData(dbgData)
	);

	alu aluUnit (
		.a(aReg),
		.b(aluB),
		.op(ctl.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	assign imemAddr = pcReg;
	assign dmemAddr = resultReg;	// load and store address comes out of EXECUTE.
	assign dmemWData = bReg;
	assign dmemWe = ctl.memWrite;
	assign pc = pcReg;
endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire cpuPkg::wordT a,
	input wire cpuPkg::wordT b,
	input wire cpuPkg::aluOpT op,
	output cpuPkg::wordT result,
	output logic zero
);
	always_comb
	begin
		case (op)
			cpuPkg::ALU_AND:
				result = a & b;
			cpuPkg::ALU_ADD:
				result = a + b;
			cpuPkg::ALU_SUB:
				result = a - b;	// zero here also serves the BEQ compare.
			cpuPkg::ALU_SLL:
				result = a << b[4:0];
			cpuPkg::ALU_MAX:
				result = (a > b) ? a : b;
			default:
				result = a + b;
		endcase
	end

	// drives both the Z flag update and the branch decision.
	assign zero = (result == '0);
endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuDefines.svh"

module registerFile (
	input wire logic clk,
	input wire logic reset,
	input wire cpuPkg::regIdxT rAddrA,
	input wire cpuPkg::regIdxT rAddrB,
	output cpuPkg::wordT rDataA,
	output cpuPkg::wordT rDataB,
	input wire logic we,
	input wire cpuPkg::regIdxT wAddr,
	input wire cpuPkg::wordT wData,
	input wire cpuPkg::regIdxT dbgAddr,
	output cpuPkg::wordT dbgData
);
	cpuPkg::wordT regs [1:`REG_COUNT-1];	// R0 has no storage.

	function automatic cpuPkg::wordT readReg(input cpuPkg::regIdxT idx);
		return (idx == '0) ? '0 : regs[idx];
	endfunction

	always_comb
	begin
		rDataA = readReg(rAddrA);
		rDataB = readReg(rAddrB);
		dbgData = readReg(dbgAddr);
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 1; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (we && wAddr != '0)
			regs[wAddr] <= wData;
	end

	wDataKnown: assert property (@(posedge clk) disable iff (!reset)
		we |-> !$isunknown(wData));
endmodule

`default_nettype wire

// ==== src/byteMemory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuDefines.svh"

module byteMemory #(
	parameter int DEPTH = `MEM_DEPTH
) (
	input wire logic clk,
	input wire logic we,
	input wire cpuPkg::wordT wAddr,
	input wire cpuPkg::wordT wData,
	input wire cpuPkg::wordT rAddr,
	output cpuPkg::wordT rData
);
	localparam int IdxW = $clog2(DEPTH);

	logic [7:0] mem [DEPTH];

	// byte address of one byte of a word, wrapped into the array.
	function automatic logic [IdxW-1:0] byteIdx(input cpuPkg::wordT addr, input int offset);
		logic [31:0] wide;
		wide = 32'(addr) + 32'(offset);
		return IdxW'(wide % DEPTH);
	endfunction

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			for (int k = 0; k < `WORD_BYTES; k++)
				mem[byteIdx(wAddr, k)] <= wData[8*(`WORD_BYTES-1-k) +: 8];	// big-endian.
		end
	end

	// reads are combinational and use the same byte order as writes.
	always_comb
	begin
		for (int k = 0; k < `WORD_BYTES; k++)
			rData[8*(`WORD_BYTES-1-k) +: 8] = mem[byteIdx(rAddr, k)];
	end

	weKnown: assert property (@(posedge clk) !$isunknown(we));
endmodule

`default_nettype wire

// ==== src/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
	logic irLoad;
	logic pcLoad;
	cpuPkg::pcSelT pcSel;
	cpuPkg::aluOpT aluOp;
	logic aluSrcImm;
	logic opLoad;
	logic resultLoad;
	logic memWrite;
	logic mdrLoad;
	logic regWrite;
	cpuPkg::wbSelT wbSel;
	logic rdIsSource;	// second read port takes Rd instead of Rs2.

	// decoded fields and the ALU zero travel back to the control unit.
	cpuPkg::opcodeT opcode;
	logic [1:0] cond;
	logic sBit;
	logic aluZero;

	modport ctrl (
		output irLoad, pcLoad, pcSel, aluOp, aluSrcImm, opLoad, resultLoad,
		output memWrite, mdrLoad, regWrite, wbSel, rdIsSource,
		input opcode, cond, sBit, aluZero
	);

	modport dp (
		input irLoad, pcLoad, pcSel, aluOp, aluSrcImm, opLoad, resultLoad,
		input memWrite, mdrLoad, regWrite, wbSel, rdIsSource,
		output opcode, cond, sBit, aluZero
	);
endinterface

`default_nettype wire

// ==== src/cpuPkg.sv ====
`default_nettype none
`include "cpuDefines.svh"

package cpuPkg;

	typedef logic [`WORD_W-1:0] wordT;
	typedef logic [`REG_ADDR_W-1:0] regIdxT;

	// codes 13 to 31 are not listed here and run as no-ops.
	typedef enum logic [4:0] {
		OP_AND = 5'd0,
		OP_ADD = 5'd1,
		OP_SUB = 5'd2,
		OP_SLL = 5'd3,
		OP_MAX = 5'd4,
		OP_ANDI = 5'd5,
		OP_ADDI = 5'd6,
		OP_LW = 5'd7,
		OP_SW = 5'd8,
		OP_BEQ = 5'd9,
		OP_J = 5'd10,
		OP_JR = 5'd11,
		OP_CALL = 5'd12
	} opcodeT;

	typedef enum logic [2:0] {
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_MAX
	} aluOpT;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK
	} stateT;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSelT;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pcSelT;

endpackage

`default_nettype wire

// ==== src/cpuDefines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_W 24
`define REG_ADDR_W 3
`define REG_COUNT 8
`define MEM_DEPTH 1024
`define WORD_BYTES 3

// instruction field positions within IR.
`define COND_HI 23
`define COND_LO 22
`define OPC_HI 21
`define OPC_LO 17
`define S_BIT 16
`define RD_HI 15
`define RS1_HI 12
`define RS2_HI 9
`define IMM10_W 10
`define IMM17_W 17

`endif
